/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_fp_simd_slice
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation reported failures"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src/fp_lane_pipe.sv */
// Elastic register chain; NumPipeRegs 0 is a plain wire path and busy_o is then always 0
`timescale 1ns/10ps
`default_nettype none

module fp_lane_pipe #(
  parameter int unsigned PayloadWidth = 8,
  parameter int unsigned NumPipeRegs  = 1
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic [PayloadWidth-1:0] payload_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic [PayloadWidth-1:0] payload_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  // Index i is the signal after i register stages
  logic [PayloadWidth-1:0] stage_data  [0:NumPipeRegs];
  logic                    stage_valid [0:NumPipeRegs];
  logic                    stage_ready [0:NumPipeRegs];

  // Entry point of the chain
  assign stage_data[0]  = payload_i;
  assign stage_valid[0] = in_valid_i;
  assign in_ready_o     = stage_ready[0];

  // ----------------------------------------------------------
  // Register stages
  // ----------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic stage_en;

    // Advance when the next stage takes data or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign stage_en       = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    // Payload only moves with a real item
    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Downstream drives the last ready
  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign payload_o                = stage_data[NumPipeRegs];
  assign out_valid_o              = stage_valid[NumPipeRegs];

  // Anything held in a register counts as in flight
  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

endmodule

`default_nettype wire

/* src/fp_noncomp_lane.sv */
// One lane; FP32 works only with LaneWidth 32, a narrower lane always computes FP16
`timescale 1ns/10ps
`default_nettype none

module fp_noncomp_lane #(
  parameter int unsigned LaneWidth   = 32,
  parameter int unsigned NumPipeRegs = 1,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic [LaneWidth-1:0]    operand_a_i,
  input  logic [LaneWidth-1:0]    operand_b_i,
  input  fpslice_pkg::operation_e op_i,
  input  fpslice_pkg::fp_format_e fmt_i,
  input  logic                    vector_i,
  input  logic [TagWidth-1:0]     tag_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic [LaneWidth-1:0]    result_o,
  output fpslice_pkg::status_t    status_o,
  output logic [TagWidth-1:0]     tag_o,
  output fpslice_pkg::fp_format_e fmt_o,
  output logic                    vector_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  localparam int unsigned WideWidth    = fpslice_pkg::fp_width(fpslice_pkg::FP32);
  localparam int unsigned FmtBits      = $bits(fpslice_pkg::fp_format_e);
  localparam int unsigned PayloadWidth =
      LaneWidth + fpslice_pkg::STATUS_BITS + TagWidth + FmtBits + 1;
  localparam logic [WideWidth-1:0] Fp16QnanWide =
      {{(WideWidth-16){1'b1}}, fpslice_pkg::FP16_QNAN};

  fpslice_pkg::fp_format_e fmt;
  fpslice_pkg::status_t    status;
  logic [WideWidth-1:0]    a_wide, b_wide, result_wide;
  logic [WideWidth-2:0]    mag_a, mag_b;
  logic                    sign_a, sign_b;
  logic                    a_nan, b_nan, a_snan, b_snan;
  logic                    a_lt_b;
  logic [PayloadWidth-1:0] payload_in, payload_out;
  logic [FmtBits-1:0]      fmt_bits;

  function automatic logic sign_of(logic [WideWidth-1:0] val, fpslice_pkg::fp_format_e f);
    return (f == fpslice_pkg::FP32) ? val[31] : val[15];
  endfunction

  function automatic logic [WideWidth-2:0] mag_of(logic [WideWidth-1:0] val,
                                                  fpslice_pkg::fp_format_e f);
    return (f == fpslice_pkg::FP32) ? val[30:0] : {16'b0, val[14:0]};
  endfunction

  // Exponent all ones and mantissa nonzero
  function automatic logic is_nan(logic [WideWidth-1:0] val, fpslice_pkg::fp_format_e f);
    if (f == fpslice_pkg::FP32) begin
      return (&val[30:23]) && (|val[22:0]);
    end
    return (&val[14:10]) && (|val[9:0]);
  endfunction

  // Signaling NaNs have the top mantissa bit clear
  function automatic logic quiet_bit(logic [WideWidth-1:0] val, fpslice_pkg::fp_format_e f);
    return (f == fpslice_pkg::FP32) ? val[22] : val[9];
  endfunction

  function automatic logic [WideWidth-1:0] with_sign(logic [WideWidth-1:0] val,
                                                     fpslice_pkg::fp_format_e f, logic s);
    logic [WideWidth-1:0] res;
    res = val;
    if (f == fpslice_pkg::FP32) begin
      res[31] = s;
    end else begin
      res[15] = s;
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Operand unpacking
  // ----------------------------------------------------------
  assign fmt    = (LaneWidth >= WideWidth) ? fmt_i : fpslice_pkg::FP16;
  assign a_wide = WideWidth'(operand_a_i);
  assign b_wide = WideWidth'(operand_b_i);
  assign sign_a = sign_of(a_wide, fmt);
  assign sign_b = sign_of(b_wide, fmt);
  assign mag_a  = mag_of(a_wide, fmt);
  assign mag_b  = mag_of(b_wide, fmt);
  assign a_nan  = is_nan(a_wide, fmt);
  assign b_nan  = is_nan(b_wide, fmt);
  assign a_snan = a_nan & ~quiet_bit(a_wide, fmt);
  assign b_snan = b_nan & ~quiet_bit(b_wide, fmt);

  // Sign-magnitude order, so -0 sorts below +0
  always_comb begin : order
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ----------------------------------------------------------
  // Operation select
  // ----------------------------------------------------------
  always_comb begin : compute
    result_wide = a_wide;
    status      = '0;
    case (op_i)
      fpslice_pkg::SGNJ:  result_wide = with_sign(a_wide, fmt, sign_b);
      fpslice_pkg::SGNJN: result_wide = with_sign(a_wide, fmt, ~sign_b);
      fpslice_pkg::SGNJX: result_wide = with_sign(a_wide, fmt, sign_a ^ sign_b);
      fpslice_pkg::FMIN, fpslice_pkg::FMAX: begin
        status.NV = a_snan | b_snan;
        if (a_nan && b_nan) begin
          result_wide = (fmt == fpslice_pkg::FP32) ? fpslice_pkg::FP32_QNAN : Fp16QnanWide;
        end else if (a_nan) begin
          result_wide = b_wide;
        end else if (b_nan) begin
          result_wide = a_wide;
        end else if (a_lt_b == (op_i == fpslice_pkg::FMIN)) begin
          result_wide = a_wide;
        end else begin
          result_wide = b_wide;
        end
      end
      default: result_wide = a_wide;
    endcase
  end

  // Result, flags, tag and aux travel as one word
  assign payload_in = {result_wide[LaneWidth-1:0], status, tag_i, fmt_i, vector_i};

  fp_lane_pipe #(
    .PayloadWidth ( PayloadWidth ),
    .NumPipeRegs  ( NumPipeRegs  )
  ) i_lane_pipe (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .flush_i     ( flush_i     ),
    .payload_i   ( payload_in  ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .payload_o   ( payload_out ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  assign {result_o, status_o, tag_o, fmt_bits, vector_o} = payload_out;
  assign fmt_o = fpslice_pkg::fp_format_e'(fmt_bits);

endmodule

`default_nettype wire

/* src/fp_result_packer.sv */
// Packs FP32 or FP16 lane results; a missing upper FP16 result is NaN-boxed with ones
`timescale 1ns/10ps
`default_nettype none

module fp_result_packer #(
  parameter bit EnableVectors = 1'b1
) (
  input  logic [fpslice_pkg::SLICE_WIDTH-1:0]                          lane0_result_i,
  input  logic [fpslice_pkg::fp_width(fpslice_pkg::FP16)-1:0]          lane1_result_i,
  input  fpslice_pkg::status_t                                         lane0_status_i,
  input  fpslice_pkg::status_t                                         lane1_status_i,
  input  logic                                                         lane1_valid_i,
  input  fpslice_pkg::fp_format_e                                      fmt_i,
  output logic [fpslice_pkg::SLICE_WIDTH-1:0]                          result_o,
  output fpslice_pkg::status_t                                         status_o
);

  localparam int unsigned HalfWidth  = fpslice_pkg::fp_width(fpslice_pkg::FP16);
  localparam int unsigned SliceWidth = fpslice_pkg::SLICE_WIDTH;

  logic                 upper_used;
  fpslice_pkg::status_t lane1_status;

  // Upper lane only contributes to vector results
  assign upper_used = EnableVectors && lane1_valid_i;

  // ----------------------------------------------------------
  // Result packing
  // ----------------------------------------------------------
  always_comb begin : pack_result
    if (fmt_i == fpslice_pkg::FP32) begin
      // Lane 0 covers the full word
      result_o = lane0_result_i;
    end else begin
      result_o[HalfWidth-1:0] = lane0_result_i[HalfWidth-1:0];
      // NaN-box when the upper half carries nothing
      result_o[SliceWidth-1:HalfWidth] = upper_used ? lane1_result_i : '1;
    end
  end

  // ----------------------------------------------------------
  // Status collapse
  // ----------------------------------------------------------
  // Flags of an idle upper lane are ignored
  assign lane1_status = upper_used ? lane1_status_i : '0;
  assign status_o     = lane0_status_i | lane1_status;

endmodule

`default_nettype wire

/* src/fp_simd_slice.sv */
// Two-lane sign-injection/min-max slice; vector ops run in both lanes only for FP16 with EnableVectors
`timescale 1ns/10ps
`default_nettype none

module fp_simd_slice #(
  parameter int unsigned NumPipeRegs   = 1,
  parameter int unsigned TagWidth      = 4,
  parameter bit          EnableVectors = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                flush_i,
  input  logic [fpslice_pkg::SLICE_WIDTH-1:0] operand_a_i,
  input  logic [fpslice_pkg::SLICE_WIDTH-1:0] operand_b_i,
  input  fpslice_pkg::operation_e             op_i,
  input  fpslice_pkg::fp_format_e             dst_fmt_i,
  input  logic                                vectorial_op_i,
  input  logic [TagWidth-1:0]                 tag_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  output logic [fpslice_pkg::SLICE_WIDTH-1:0] result_o,
  output fpslice_pkg::status_t                status_o,
  output logic [TagWidth-1:0]                 tag_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic                                busy_o
);

  localparam int unsigned Lane0Width = fpslice_pkg::fp_width(fpslice_pkg::FP32);
  localparam int unsigned Lane1Width = fpslice_pkg::fp_width(fpslice_pkg::FP16);

  logic                              vector_op;
  logic [fpslice_pkg::NUM_LANES-1:0] lane_busy;
  logic                              lane0_busy, lane1_busy;
  logic [Lane0Width-1:0]             lane0_result;
  fpslice_pkg::status_t              lane0_status;
  fpslice_pkg::fp_format_e           lane0_fmt;
  logic                              lane0_vector;
  logic [Lane1Width-1:0]             lane1_result;
  fpslice_pkg::status_t              lane1_status;
  logic                              lane1_out_valid;

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  // Vector mode needs two FP16 values in the word
  assign vector_op = vectorial_op_i & EnableVectors & (dst_fmt_i == fpslice_pkg::FP16);

  // Lane 0 always works and owns the upstream handshake
  fp_noncomp_lane #(
    .LaneWidth   ( Lane0Width  ),
    .NumPipeRegs ( NumPipeRegs ),
    .TagWidth    ( TagWidth    )
  ) i_lane0 (
    .clk_i       ( clk_i                    ),
    .reset_i     ( reset_i                  ),
    .flush_i     ( flush_i                  ),
    .operand_a_i ( operand_a_i[Lane0Width-1:0] ),
    .operand_b_i ( operand_b_i[Lane0Width-1:0] ),
    .op_i        ( op_i                     ),
    .fmt_i       ( dst_fmt_i                ),
    .vector_i    ( vector_op                ),
    .tag_i       ( tag_i                    ),
    .in_valid_i  ( in_valid_i               ),
    .in_ready_o  ( in_ready_o               ),
    .result_o    ( lane0_result             ),
    .status_o    ( lane0_status             ),
    .tag_o       ( tag_o                    ),
    .fmt_o       ( lane0_fmt                ),
    .vector_o    ( lane0_vector             ),
    .out_valid_o ( out_valid_o              ),
    .out_ready_i ( out_ready_i              ),
    .busy_o      ( lane0_busy               )
  );

  // ----------------------------------------------------------
  // Upper lane, vector items only
  // ----------------------------------------------------------
  if (EnableVectors) begin : gen_lane1
    logic lane1_in_valid, lane1_out_ready, lane1_valid_raw;

    // Take an item only in the cycle lane 0 takes its twin
    assign lane1_in_valid  = in_valid_i & vector_op & in_ready_o;
    // Leave together with the twin at lane 0's output
    assign lane1_out_ready = out_ready_i & lane0_vector;

    fp_noncomp_lane #(
      .LaneWidth   ( Lane1Width  ),
      .NumPipeRegs ( NumPipeRegs ),
      .TagWidth    ( TagWidth    )
    ) i_lane1 (
      .clk_i       ( clk_i                                  ),
      .reset_i     ( reset_i                                ),
      .flush_i     ( flush_i                                ),
      .operand_a_i ( operand_a_i[2*Lane1Width-1:Lane1Width] ),
      .operand_b_i ( operand_b_i[2*Lane1Width-1:Lane1Width] ),
      .op_i        ( op_i                                   ),
      .fmt_i       ( dst_fmt_i                              ),
      .vector_i    ( vector_op                              ),
      .tag_i       ( tag_i                                  ),
      .in_valid_i  ( lane1_in_valid                         ),
      .in_ready_o  (                                        ),
      .result_o    ( lane1_result                           ),
      .status_o    ( lane1_status                           ),
      .tag_o       (                                        ),
      .fmt_o       (                                        ),
      .vector_o    (                                        ),
      .out_valid_o ( lane1_valid_raw                        ),
      .out_ready_i ( lane1_out_ready                        ),
      .busy_o      ( lane1_busy                             )
    );

    assign lane1_out_valid = lane1_valid_raw & lane0_vector;
  end else begin : gen_no_lane1
    assign lane1_result    = '1;
    assign lane1_status    = '0;
    assign lane1_out_valid = 1'b0;
    assign lane1_busy      = 1'b0;
  end

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  fp_result_packer #(
    .EnableVectors ( EnableVectors )
  ) i_packer (
    .lane0_result_i ( lane0_result    ),
    .lane1_result_i ( lane1_result    ),
    .lane0_status_i ( lane0_status    ),
    .lane1_status_i ( lane1_status    ),
    .lane1_valid_i  ( lane1_out_valid ),
    .fmt_i          ( lane0_fmt       ),
    .result_o       ( result_o        ),
    .status_o       ( status_o        )
  );

  assign lane_busy = {lane1_busy, lane0_busy};
  assign busy_o    = |lane_busy;

endmodule

`default_nettype wire

/* src/fpslice_pkg.sv */
// Shared types for the slice; only FP32 and FP16 exist, and lane 1 can hold FP16 only
`default_nettype none

package fpslice_pkg;

  // ----------------------------------------------------------
  // Slice geometry
  // ----------------------------------------------------------
  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 2;

  // ----------------------------------------------------------
  // Formats and opcodes
  // ----------------------------------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // Non-computational group only
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } operation_e;

  // IEEE 754 exception flags, in the usual fflags order
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  localparam int unsigned STATUS_BITS = $bits(status_t);

  // Canonical quiet NaNs
  localparam logic [31:0] FP32_QNAN = 32'h7FC0_0000;
  localparam logic [15:0] FP16_QNAN = 16'h7E00;

  // Total bit width of a format
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP32: return 32;
      FP16: return 16;
      default: return 32;
    endcase
  endfunction

endpackage

`default_nettype wire

/* testbench/fp_simd_slice_assert.sv */
// Handshake properties for the slice top; valid implies busy only holds with NumPipeRegs of 1 or more
`timescale 1ns/10ps
`default_nettype none

module fp_simd_slice_assert #(
  parameter int unsigned TagWidth = 4
) (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 flush_i,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic                 busy_o,
  input logic [31:0]          result_o,
  input fpslice_pkg::status_t status_o,
  input logic [TagWidth-1:0]  tag_o
);

  // Number of property failures so far
  int unsigned failures = 0;

  // A stalled item stays put until it leaves
  property stall_holds_output;
    @(posedge clk_i) disable iff (reset_i)
      (out_valid_o && !out_ready_i && !flush_i) |=>
        (out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));
  endproperty

  property idle_after_reset;
    @(posedge clk_i) reset_i |=> !out_valid_o;
  endproperty

  property valid_means_busy;
    @(posedge clk_i) disable iff (reset_i) out_valid_o |-> busy_o;
  endproperty

  assert property (stall_holds_output) else begin
    $error("Output changed while stalled");
    failures++;
  end
  assert property (idle_after_reset) else begin
    $error("out_valid_o high right after reset");
    failures++;
  end
  assert property (valid_means_busy) else begin
    $error("out_valid_o high while busy_o is low");
    failures++;
  end

endmodule

`default_nettype wire

/* testbench/tb_fp_simd_slice.sv */
// Runs the slice with NumPipeRegs 2 and a 4-bit tag; the table must stay at 16 entries or fewer
`timescale 1ns/10ps
`default_nettype none

module tb_fp_simd_slice;

  localparam int unsigned num_pipe_regs = 2;
  localparam int unsigned tag_width     = 4;
  localparam int unsigned clk_period    = 100;
  localparam logic [4:0]  nv_flag       = 5'b1_0000;

  typedef struct {
    string                   name;
    fpslice_pkg::operation_e op;
    fpslice_pkg::fp_format_e fmt;
    logic                    vec;
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             result;
    logic [4:0]              status;
  } entry_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    flush_i;
  logic [31:0]             operand_a_i;
  logic [31:0]             operand_b_i;
  fpslice_pkg::operation_e op_i;
  fpslice_pkg::fp_format_e dst_fmt_i;
  logic                    vectorial_op_i;
  logic [tag_width-1:0]    tag_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  logic [31:0]             result_o;
  fpslice_pkg::status_t    status_o;
  logic [tag_width-1:0]    tag_o;
  logic                    out_valid_o;
  logic                    out_ready_i;
  logic                    busy_o;

  entry_t      table_q[$];
  integer      seed = 32'hf864323f;
  logic        random_ready = 1'b0;
  int unsigned timeout_limit = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  fp_simd_slice #(
    .NumPipeRegs   ( num_pipe_regs ),
    .TagWidth      ( tag_width     ),
    .EnableVectors ( 1'b1          )
  ) dut (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .flush_i        ( flush_i        ),
    .operand_a_i    ( operand_a_i    ),
    .operand_b_i    ( operand_b_i    ),
    .op_i           ( op_i           ),
    .dst_fmt_i      ( dst_fmt_i      ),
    .vectorial_op_i ( vectorial_op_i ),
    .tag_i          ( tag_i          ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  bind fp_simd_slice fp_simd_slice_assert #(
    .TagWidth ( TagWidth )
  ) i_handshake_assert (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .flush_i     ( flush_i     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       )
  );

  // ------------------------------------------------------------
  // Clock, back-pressure and watchdog
  // ------------------------------------------------------------
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin : ready_gen
    integer rnd;
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      rnd = $random(seed);
      out_ready_i <= random_ready ? rnd[0] : 1'b0;
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles <= timeout_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped completing items", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  // ------------------------------------------------------------
  // Table and helpers
  // ------------------------------------------------------------
  task automatic add_entry(input string name, input fpslice_pkg::operation_e op,
                           input fpslice_pkg::fp_format_e fmt, input logic vec,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] result, input logic [4:0] status);
    entry_t e;
    e.name   = name;
    e.op     = op;
    e.fmt    = fmt;
    e.vec    = vec;
    e.a      = a;
    e.b      = b;
    e.result = result;
    e.status = status;
    table_q.push_back(e);
  endtask

  // Vector operands hold the upper FP16 value in bits 31:16
  task automatic load_table();
    add_entry("fp32_sgnj", fpslice_pkg::SGNJ, fpslice_pkg::FP32, 1'b0,
              32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, 5'h00);
    add_entry("fp32_sgnjn", fpslice_pkg::SGNJN, fpslice_pkg::FP32, 1'b0,
              32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000, 5'h00);
    add_entry("fp32_sgnjx", fpslice_pkg::SGNJX, fpslice_pkg::FP32, 1'b0,
              32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, 5'h00);
    add_entry("fp32_fmin", fpslice_pkg::FMIN, fpslice_pkg::FP32, 1'b0,
              32'h4040_0000, 32'hC000_0000, 32'hC000_0000, 5'h00);
    add_entry("fp32_fmax", fpslice_pkg::FMAX, fpslice_pkg::FP32, 1'b0,
              32'h4040_0000, 32'hC000_0000, 32'h4040_0000, 5'h00);
    add_entry("fp32_fmin_zeros", fpslice_pkg::FMIN, fpslice_pkg::FP32, 1'b0,
              32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 5'h00);
    add_entry("fp32_fmax_zeros", fpslice_pkg::FMAX, fpslice_pkg::FP32, 1'b0,
              32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 5'h00);
    add_entry("fp32_fmin_qnan", fpslice_pkg::FMIN, fpslice_pkg::FP32, 1'b0,
              32'h7FC0_0000, 32'h3F80_0000, 32'h3F80_0000, 5'h00);
    add_entry("fp32_fmax_two_nan", fpslice_pkg::FMAX, fpslice_pkg::FP32, 1'b0,
              32'h7FC0_0001, 32'hFFC0_0000, 32'h7FC0_0000, 5'h00);
    add_entry("fp32_fmin_snan", fpslice_pkg::FMIN, fpslice_pkg::FP32, 1'b0,
              32'h7F80_0001, 32'h4000_0000, 32'h4000_0000, nv_flag);
    add_entry("vec_sgnj", fpslice_pkg::SGNJ, fpslice_pkg::FP16, 1'b1,
              32'h3C00_4000, 32'h8000_0000, 32'hBC00_4000, 5'h00);
    add_entry("vec_fmin", fpslice_pkg::FMIN, fpslice_pkg::FP16, 1'b1,
              32'h4200_C000, 32'h3C00_BC00, 32'h3C00_C000, 5'h00);
    add_entry("vec_fmax_snan_low", fpslice_pkg::FMAX, fpslice_pkg::FP16, 1'b1,
              32'h7E00_7D00, 32'h4000_3C00, 32'h4000_3C00, nv_flag);
    // Scalar FP16 right ahead of a vector item that flags NV in the upper lane
    add_entry("fp16_scalar_sgnjn", fpslice_pkg::SGNJN, fpslice_pkg::FP16, 1'b0,
              32'h1234_3C00, 32'h0000_3C00, 32'hFFFF_BC00, 5'h00);
    add_entry("vec_fmin_two_nan_high", fpslice_pkg::FMIN, fpslice_pkg::FP16, 1'b1,
              32'h7C01_8000, 32'hFE00_0000, 32'h7E00_8000, nv_flag);
    add_entry("fp32_with_vec_flag", fpslice_pkg::SGNJ, fpslice_pkg::FP32, 1'b1,
              32'h3F80_0000, 32'h8000_0000, 32'hBF80_0000, 5'h00);
  endtask

  task automatic drive_entry(input int idx);
    operand_a_i    <= table_q[idx].a;
    operand_b_i    <= table_q[idx].b;
    op_i           <= table_q[idx].op;
    dst_fmt_i      <= table_q[idx].fmt;
    vectorial_op_i <= table_q[idx].vec;
    tag_i          <= tag_width'(idx);
    in_valid_i     <= 1'b1;
  endtask

  task automatic report_test(input string name, input logic ok);
    if (ok) begin
      pass_count++;
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: did not pass", name);
    end
  endtask

  task automatic check_item(input int idx);
    entry_t e;
    logic   ok;
    e  = table_q[idx];
    ok = 1'b1;
    assert (tag_o == tag_width'(idx)) else begin
      $display("FAIL %s tag expected %0d actual %0d", e.name, idx, tag_o);
      ok = 1'b0;
    end
    assert (result_o == e.result) else begin
      $display("FAIL %s result expected %h actual %h", e.name, e.result, result_o);
      ok = 1'b0;
    end
    assert (status_o == e.status) else begin
      $display("FAIL %s status expected %b actual %b", e.name, e.status, status_o);
      ok = 1'b0;
    end
    report_test(e.name, ok);
  endtask

  // Handshakes are judged at the falling edge and take place at the next rising edge
  task automatic offer_items();
    for (int i = 0; i < table_q.size(); i++) begin
      @(posedge clk_i);
      drive_entry(i);
      do begin
        @(negedge clk_i);
      end while (!in_ready_o);
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic collect_items();
    int idx;
    idx = 0;
    while (idx < table_q.size()) begin
      @(negedge clk_i);
      if (out_valid_o && out_ready_i) begin
        check_item(idx);
        idx++;
      end
    end
  endtask

  task automatic run_table();
    random_ready = 1'b1;
    fork
      offer_items();
      collect_items();
    join
  endtask

  // Two items parked in the stalled pipe, then flushed
  task automatic check_flush();
    logic ok;
    ok           = 1'b1;
    random_ready = 1'b0;
    @(posedge clk_i);
    drive_entry(0);
    @(posedge clk_i);
    drive_entry(1);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(negedge clk_i);
    assert (busy_o) else begin
      $display("Flush test: no items were in flight before the flush");
      ok = 1'b0;
    end
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o) else begin
      $display("Flush test: out_valid_o or busy_o still high after the flush");
      ok = 1'b0;
    end
    report_test("flush", ok);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin : main
    logic reset_ok;
    reset_i        = 1'b1;
    flush_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = fpslice_pkg::SGNJ;
    dst_fmt_i      = fpslice_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    reset_ok       = 1'b1;
    load_table();
    // Two table passes plus the flush items
    timeout_limit = (2 * table_q.size() + 2) * 8 * (num_pipe_regs + 1) + 100;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && !busy_o) else begin
      $display("Reset test: handshake outputs are not idle after reset");
      reset_ok = 1'b0;
    end
    report_test("reset", reset_ok);
    run_table();
    check_flush();
    run_table();
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && dut.i_handshake_assert.failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/fpslice_pkg.sv
src/fp_lane_pipe.sv
src/fp_noncomp_lane.sv
src/fp_result_packer.sv
src/fp_simd_slice.sv
testbench/fp_simd_slice_assert.sv
testbench/tb_fp_simd_slice.sv
